// File: hw/core_pkg.sv
// Shared register codes, micro-op encodings, command word layout and host address map
`default_nettype none

package core_pkg;

	// Register codes on wr_sel and in the command word
	typedef enum logic [3:0] {
		REG_A   = 4'd0,
		REG_B   = 4'd1,
		REG_C   = 4'd2,
		REG_D   = 4'd3,
		REG_E   = 4'd4,
		REG_H   = 4'd5,
		REG_L   = 4'd6,
		REG_IR  = 4'd7,
		REG_Z   = 4'd8,
		REG_W   = 4'd9,
		REG_SPL = 4'd10,
		REG_SPH = 4'd11,
		REG_PCL = 4'd12,
		REG_PCH = 4'd13		// 14 and 15 unused
	} reg_sel_e;

	typedef enum logic [3:0] {
		OP_NOP    = 4'd0,
		OP_LD_IMM = 4'd1,
		OP_MOV    = 4'd2,
		OP_IDU    = 4'd3,
		OP_JP_ZW  = 4'd4,
		OP_FETCH  = 4'd5		// Everything above is illegal
	} uop_op_e;

	// Fields hold raw codes, since illegal values must survive decode
	typedef union packed {
		struct packed {
			logic [3:0] op;
			logic [3:0] dst;
			logic [3:0] src;
			logic       dec;		// IDU direction
			logic [2:0] spare;
		} mv;
		struct packed {
			logic [3:0] op;
			logic [3:0] dst;
			logic [7:0] imm;
		} im;
	} uop_t;

	// Host word addresses
	localparam logic [2:0] ADDR_CMD  = 3'd0;
	localparam logic [2:0] ADDR_BCDE = 3'd1;
	localparam logic [2:0] ADDR_HLAI = 3'd2;
	localparam logic [2:0] ADDR_SPPC = 3'd3;
	localparam logic [2:0] ADDR_WZ   = 3'd4;
	localparam logic [2:0] ADDR_STAT = 3'd5;

	// A pair is named by its high register
	function automatic logic is_pair(input logic [3:0] code);
		case (code)
			REG_B, REG_D, REG_H, REG_SPH, REG_PCH, REG_W: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

endpackage

`default_nettype wire

// File: hw/reg_file.sv
// General registers A to L plus IR, written through the shared strobe port and read in parallel
`default_nettype none

module reg_file (
	input wire clk,
	input wire reset,
	input wire wr_en,
	input wire [3:0] wr_sel,
	input wire wr_pair,
	input wire [15:0] wr_data,
	output logic [7:0] reg_a,
	output logic [7:0] reg_b,
	output logic [7:0] reg_c,
	output logic [7:0] reg_d,
	output logic [7:0] reg_e,
	output logic [7:0] reg_h,
	output logic [7:0] reg_l,
	output logic [7:0] reg_ir
);

	always_ff @(posedge clk) begin
		if (reset) begin
			reg_a <= 8'h00;
			reg_b <= 8'h00;
			reg_c <= 8'h00;
			reg_d <= 8'h00;
			reg_e <= 8'h00;
			reg_h <= 8'h00;
			reg_l <= 8'h00;
			reg_ir <= 8'h00;
		end else if (wr_en) begin
			if (wr_pair) begin
				// High byte to the named register, low byte to its partner
				case (wr_sel)
					core_pkg::REG_B: begin
						reg_b <= wr_data[15:8];
						reg_c <= wr_data[7:0];
					end
					core_pkg::REG_D: begin
						reg_d <= wr_data[15:8];
						reg_e <= wr_data[7:0];
					end
					core_pkg::REG_H: begin
						reg_h <= wr_data[15:8];
						reg_l <= wr_data[7:0];
					end
					default: ;		// SP, PC and WZ live in addr_unit
				endcase
			end else begin
				case (wr_sel)
					core_pkg::REG_A: reg_a <= wr_data[7:0];
					core_pkg::REG_B: reg_b <= wr_data[7:0];
					core_pkg::REG_C: reg_c <= wr_data[7:0];
					core_pkg::REG_D: reg_d <= wr_data[7:0];
					core_pkg::REG_E: reg_e <= wr_data[7:0];
					core_pkg::REG_H: reg_h <= wr_data[7:0];
					core_pkg::REG_L: reg_l <= wr_data[7:0];
					core_pkg::REG_IR: reg_ir <= wr_data[7:0];
					default: ;		// Not owned here
				endcase
			end
		end
	end

	// The controller only ever names a high register for a pair write
	pair_sel_legal: assert property (
		@(posedge clk) disable iff (reset)
		(wr_en && wr_pair) |-> core_pkg::is_pair(wr_sel)
	);

endmodule

`default_nettype wire

// File: hw/addr_unit.sv
// Address side registers Z, W, SP and PC with the 16-bit increment/decrement unit
`default_nettype none

module addr_unit #(
	parameter logic [15:0] RESET_PC = 16'h0000
) (
	input wire clk,
	input wire reset,
	input wire wr_en,
	input wire [3:0] wr_sel,
	input wire wr_pair,
	input wire [15:0] wr_data,
	input wire pc_inc,
	input wire [15:0] idu_in,
	input wire idu_dec,
	output logic [7:0] adl,
	output logic [7:0] adh,
	output logic [7:0] reg_z,
	output logic [7:0] reg_w,
	output logic [15:0] reg_sp,
	output logic [15:0] reg_pc
);

	logic [15:0] idu_out;

	// IDU wraps at 16 bits in both directions
	always_comb begin
		if (idu_dec)
			idu_out = idu_in - 16'd1;
		else
			idu_out = idu_in + 16'd1;
	end

	assign adl = idu_out[7:0];
	assign adh = idu_out[15:8];

	always_ff @(posedge clk) begin
		if (reset) begin
			reg_z <= 8'h00;
			reg_w <= 8'h00;
			reg_sp <= 16'h0000;
			reg_pc <= RESET_PC;
		end else begin
			if (wr_en) begin
				if (wr_pair) begin
					case (wr_sel)
						core_pkg::REG_SPH: reg_sp <= wr_data;
						core_pkg::REG_PCH: reg_pc <= wr_data;
						core_pkg::REG_W: begin
							reg_w <= wr_data[15:8];
							reg_z <= wr_data[7:0];
						end
						default: ;		// BC, DE, HL in reg_file
					endcase
				end else begin
					case (wr_sel)
						core_pkg::REG_Z: reg_z <= wr_data[7:0];
						core_pkg::REG_W: reg_w <= wr_data[7:0];
						core_pkg::REG_SPL: reg_sp[7:0] <= wr_data[7:0];
						core_pkg::REG_SPH: reg_sp[15:8] <= wr_data[7:0];
						core_pkg::REG_PCL: reg_pc[7:0] <= wr_data[7:0];
						core_pkg::REG_PCH: reg_pc[15:8] <= wr_data[7:0];
						default: ;
					endcase
				end
			end
			// Opcode fetch advances PC from the IDU
			if (pc_inc)
				reg_pc <= {adh, adl};
		end
	end

	// First cycle out of reset sees the vector
	pc_reset_vector: assert property (
		@(posedge clk)
		$fell(reset) |-> (reg_pc == RESET_PC)
	);

endmodule

`default_nettype wire

// File: hw/uop_ctrl.sv
// Wishbone slave that decodes micro-op commands, steers both register blocks and serves readback
`default_nettype none

module uop_ctrl (
	input wire clk,
	input wire reset,
	input wire cyc,
	input wire stb,
	input wire we,
	input wire [2:0] adr,
	input wire [31:0] dat_w,
	input wire [3:0] sel,
	output logic [31:0] dat_r,
	output logic ack,
	output logic wr_en,
	output logic [3:0] wr_sel,
	output logic wr_pair,
	output logic [15:0] wr_data,
	output logic pc_inc,
	output logic [15:0] idu_in,
	output logic idu_dec,
	input wire [7:0] adl,
	input wire [7:0] adh,
	input wire [7:0] reg_a,
	input wire [7:0] reg_b,
	input wire [7:0] reg_c,
	input wire [7:0] reg_d,
	input wire [7:0] reg_e,
	input wire [7:0] reg_h,
	input wire [7:0] reg_l,
	input wire [7:0] reg_ir,
	input wire [7:0] reg_z,
	input wire [7:0] reg_w,
	input wire [15:0] reg_sp,
	input wire [15:0] reg_pc
);

	core_pkg::uop_t cmd_in;
	core_pkg::uop_t cmd_q;		// Last command written
	logic req_q;			// Request seen last cycle
	logic accept;
	logic cmd_wr;
	logic legal;
	logic [7:0] src_byte;
	logic [15:0] pair_val;
	logic [15:0] exec_cnt;
	logic illegal_seen;
	logic [31:0] rd_data;

	assign cmd_in = dat_w[15:0];
	assign accept = cyc & stb & ~req_q;		// One transfer per stb assertion
	assign cmd_wr = accept & we & (adr == core_pkg::ADDR_CMD) & (&sel[1:0]);

	// Source bus for MOV
	always_comb begin
		case (cmd_in.mv.src)
			core_pkg::REG_A: src_byte = reg_a;
			core_pkg::REG_B: src_byte = reg_b;
			core_pkg::REG_C: src_byte = reg_c;
			core_pkg::REG_D: src_byte = reg_d;
			core_pkg::REG_E: src_byte = reg_e;
			core_pkg::REG_H: src_byte = reg_h;
			core_pkg::REG_L: src_byte = reg_l;
			core_pkg::REG_IR: src_byte = reg_ir;
			core_pkg::REG_Z: src_byte = reg_z;
			core_pkg::REG_W: src_byte = reg_w;
			core_pkg::REG_SPL: src_byte = reg_sp[7:0];
			core_pkg::REG_SPH: src_byte = reg_sp[15:8];
			core_pkg::REG_PCL: src_byte = reg_pc[7:0];
			core_pkg::REG_PCH: src_byte = reg_pc[15:8];
			default: src_byte = 8'h00;
		endcase
	end

	// Pair operand for the IDU
	always_comb begin
		case (cmd_in.mv.dst)
			core_pkg::REG_B: pair_val = {reg_b, reg_c};
			core_pkg::REG_D: pair_val = {reg_d, reg_e};
			core_pkg::REG_H: pair_val = {reg_h, reg_l};
			core_pkg::REG_SPH: pair_val = reg_sp;
			core_pkg::REG_W: pair_val = {reg_w, reg_z};
			default: pair_val = reg_pc;
		endcase
	end

	// NOP, JP and FETCH ignore dst
	always_comb begin
		case (cmd_in.mv.op)
			core_pkg::OP_NOP, core_pkg::OP_JP_ZW, core_pkg::OP_FETCH: legal = 1'b1;
			core_pkg::OP_LD_IMM, core_pkg::OP_MOV: legal = cmd_in.mv.dst <= 4'd13;
			core_pkg::OP_IDU: legal = core_pkg::is_pair(cmd_in.mv.dst);
			default: legal = 1'b0;
		endcase
	end

	always_comb begin
		wr_en = 1'b0;
		wr_sel = cmd_in.mv.dst;
		wr_pair = 1'b0;
		wr_data = {8'h00, cmd_in.im.imm};
		pc_inc = 1'b0;
		idu_in = reg_pc;		// FETCH default, increment PC
		idu_dec = 1'b0;
		case (cmd_in.mv.op)
			core_pkg::OP_LD_IMM: wr_en = cmd_wr & legal;
			core_pkg::OP_MOV: begin
				wr_en = cmd_wr & legal;
				wr_data = {8'h00, src_byte};
			end
			core_pkg::OP_IDU: begin
				wr_en = cmd_wr & legal;
				wr_pair = 1'b1;
				wr_data = {adh, adl};
				idu_in = pair_val;
				idu_dec = cmd_in.mv.dec;
			end
			core_pkg::OP_JP_ZW: begin
				wr_en = cmd_wr;
				wr_sel = core_pkg::REG_PCH;
				wr_pair = 1'b1;
				wr_data = {reg_w, reg_z};
			end
			core_pkg::OP_FETCH: begin
				wr_en = cmd_wr;		// IR takes imm
				wr_sel = core_pkg::REG_IR;
				pc_inc = cmd_wr;
			end
			default: ;
		endcase
	end

	always_comb begin
		case (adr)
			core_pkg::ADDR_CMD: rd_data = {16'h0000, cmd_q};
			core_pkg::ADDR_BCDE: rd_data = {reg_b, reg_c, reg_d, reg_e};
			core_pkg::ADDR_HLAI: rd_data = {reg_h, reg_l, reg_a, reg_ir};
			core_pkg::ADDR_SPPC: rd_data = {reg_sp, reg_pc};
			core_pkg::ADDR_WZ: rd_data = {16'h0000, reg_w, reg_z};
			core_pkg::ADDR_STAT: rd_data = {illegal_seen, 15'h0000, exec_cnt};
			default: rd_data = 32'h0000_0000;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ack <= 1'b0;
			req_q <= 1'b0;
			cmd_q <= '0;
			exec_cnt <= 16'h0000;
			illegal_seen <= 1'b0;
		end else begin
			ack <= accept;
			req_q <= cyc & stb;
			if (cmd_wr) begin
				cmd_q <= cmd_in;
				if (legal)
					exec_cnt <= exec_cnt + 16'd1;
				else
					illegal_seen <= 1'b1;		// Sticky until reset
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			dat_r <= rd_data;
	end

	ack_after_req: assert property (
		@(posedge clk) disable iff (reset)
		ack |-> $past(cyc && stb)
	);

	// Handshake allows one execute per request
	wr_en_single: assert property (
		@(posedge clk) disable iff (reset)
		wr_en |=> !wr_en
	);

endmodule

`default_nettype wire

// File: hw/core_datapath_top.sv
// Top of the register and address datapath, exposing the Wishbone host port
`default_nettype none

module core_datapath_top #(
	parameter logic [15:0] RESET_PC = 16'h0000
) (
	input wire clk,
	input wire reset,
	input wire cyc,
	input wire stb,
	input wire we,
	input wire [2:0] adr,
	input wire [31:0] dat_w,
	input wire [3:0] sel,
	output logic [31:0] dat_r,
	output logic ack
);

	logic wr_en;
	logic [3:0] wr_sel;
	logic wr_pair;
	logic [15:0] wr_data;
	logic pc_inc;
	logic [15:0] idu_in;
	logic idu_dec;
	logic [7:0] adl;
	logic [7:0] adh;
	logic [7:0] reg_a;
	logic [7:0] reg_b;
	logic [7:0] reg_c;
	logic [7:0] reg_d;
	logic [7:0] reg_e;
	logic [7:0] reg_h;
	logic [7:0] reg_l;
	logic [7:0] reg_ir;
	logic [7:0] reg_z;
	logic [7:0] reg_w;
	logic [15:0] reg_sp;
	logic [15:0] reg_pc;

	uop_ctrl uop_ctrl_i (
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.sel(sel),
		.dat_r(dat_r),
		.ack(ack),
		.wr_en(wr_en),
		.wr_sel(wr_sel),
		.wr_pair(wr_pair),
		.wr_data(wr_data),
		.pc_inc(pc_inc),
		.idu_in(idu_in),
		.idu_dec(idu_dec),
		.adl(adl),
		.adh(adh),
		.reg_a(reg_a),
		.reg_b(reg_b),
		.reg_c(reg_c),
		.reg_d(reg_d),
		.reg_e(reg_e),
		.reg_h(reg_h),
		.reg_l(reg_l),
		.reg_ir(reg_ir),
		.reg_z(reg_z),
		.reg_w(reg_w),
		.reg_sp(reg_sp),
		.reg_pc(reg_pc)
	);

	reg_file reg_file_i (
		.clk(clk),
		.reset(reset),
		.wr_en(wr_en),
		.wr_sel(wr_sel),
		.wr_pair(wr_pair),
		.wr_data(wr_data),
		.reg_a(reg_a),
		.reg_b(reg_b),
		.reg_c(reg_c),
		.reg_d(reg_d),
		.reg_e(reg_e),
		.reg_h(reg_h),
		.reg_l(reg_l),
		.reg_ir(reg_ir)
	);

	addr_unit #(
		.RESET_PC(RESET_PC)
	) addr_unit_i (
		.clk(clk),
		.reset(reset),
		.wr_en(wr_en),
		.wr_sel(wr_sel),
		.wr_pair(wr_pair),
		.wr_data(wr_data),
		.pc_inc(pc_inc),
		.idu_in(idu_in),
		.idu_dec(idu_dec),
		.adl(adl),
		.adh(adh),
		.reg_z(reg_z),
		.reg_w(reg_w),
		.reg_sp(reg_sp),
		.reg_pc(reg_pc)
	);

endmodule

`default_nettype wire

// File: test/tb_core.sv
// Testbench for the datapath top; runs micro-op commands over Wishbone and checks readback
`default_nettype none

module tb_core;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [15:0] START_PC = 16'h0150;
	localparam int CYCLE_LIMIT = 4000;		// ~360 transfers of a few cycles each, plus margin
	localparam logic [31:0] SEED = 32'h82bd2c7d;

	logic clk;
	logic reset;
	logic cyc;
	logic stb;
	logic we;
	logic [2:0] adr;
	logic [31:0] dat_w;
	logic [3:0] sel;
	logic [31:0] dat_r;
	logic ack;

	logic [7:0] mdl [0:15];		// Reference registers, indexed by register code
	logic [15:0] mdl_cnt;
	logic mdl_sticky;
	logic [15:0] mdl_cmd;

	string test_name;
	int test_cnt;
	int failed_tests;
	int errs_at_start;
	int error_cnt;
	int check_cnt;
	int xact_cnt;
	int ack_cnt;
	int ack_len_errs;
	int ack_req_errs;
	int cycle_cnt;

	core_datapath_top #(
		.RESET_PC(START_PC)
	) core_datapath_top_i (
		.clk(clk),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.sel(sel),
		.dat_r(dat_r),
		.ack(ack)
	);

	always #4 clk = ~clk;

	// Ack pulses seen by the host side
	always @(posedge clk) begin
		if (!reset && ack)
			ack_cnt <= ack_cnt + 1;
	end

	ack_one_cycle: assert property (
		@(posedge clk) disable iff (reset)
		ack |=> !ack
	) else begin
		ack_len_errs++;
		$display("ack stayed high for more than one cycle");
	end

	ack_follows_request: assert property (
		@(posedge clk) disable iff (reset)
		ack |-> $past(cyc && stb)
	) else begin
		ack_req_errs++;
		$display("ack rose without a bus request");
	end

	function automatic int total_errors();
		return error_cnt + ack_len_errs + ack_req_errs;
	endfunction

	// Low partner of a pair or 15 if the code names no pair
	function automatic logic [3:0] partner_of(input logic [3:0] code);
		case (code)
			core_pkg::REG_B: return core_pkg::REG_C;
			core_pkg::REG_D: return core_pkg::REG_E;
			core_pkg::REG_H: return core_pkg::REG_L;
			core_pkg::REG_W: return core_pkg::REG_Z;
			core_pkg::REG_SPH: return core_pkg::REG_SPL;
			core_pkg::REG_PCH: return core_pkg::REG_PCL;
			default: return 4'd15;
		endcase
	endfunction

	task automatic model_reset();
		for (int i = 0; i < 16; i++)
			mdl[i] = 8'h00;
		mdl[core_pkg::REG_PCH] = START_PC[15:8];
		mdl[core_pkg::REG_PCL] = START_PC[7:0];
		mdl_cnt = 16'h0000;
		mdl_sticky = 1'b0;
		mdl_cmd = 16'h0000;
	endtask

	task automatic model_apply(input logic [15:0] cmd);
		logic [3:0] op;
		logic [3:0] dst;
		logic [3:0] src;
		logic [3:0] lo;
		logic [15:0] pv;
		logic ok;
		op = cmd[15:12];
		dst = cmd[11:8];
		src = cmd[7:4];
		lo = partner_of(dst);
		ok = 1'b1;
		case (op)
			core_pkg::OP_NOP: ;
			core_pkg::OP_LD_IMM: begin
				if (dst <= 4'd13)
					mdl[dst] = cmd[7:0];
				else
					ok = 1'b0;
			end
			core_pkg::OP_MOV: begin
				if (dst <= 4'd13)
					mdl[dst] = (src <= 4'd13) ? mdl[src] : 8'h00;
				else
					ok = 1'b0;
			end
			core_pkg::OP_IDU: begin
				if (lo != 4'd15) begin
					pv = {mdl[dst], mdl[lo]};
					pv = cmd[3] ? pv - 16'd1 : pv + 16'd1;		// Bit 3 selects decrement
					mdl[dst] = pv[15:8];
					mdl[lo] = pv[7:0];
				end else begin
					ok = 1'b0;
				end
			end
			core_pkg::OP_JP_ZW: begin
				mdl[core_pkg::REG_PCH] = mdl[core_pkg::REG_W];
				mdl[core_pkg::REG_PCL] = mdl[core_pkg::REG_Z];
			end
			core_pkg::OP_FETCH: begin
				mdl[core_pkg::REG_IR] = cmd[7:0];
				pv = {mdl[core_pkg::REG_PCH], mdl[core_pkg::REG_PCL]} + 16'd1;
				mdl[core_pkg::REG_PCH] = pv[15:8];
				mdl[core_pkg::REG_PCL] = pv[7:0];
			end
			default: ok = 1'b0;
		endcase
		if (ok)
			mdl_cnt = mdl_cnt + 16'd1;
		else
			mdl_sticky = 1'b1;
		mdl_cmd = cmd;
	endtask

	// Holds reset for 4 cycles and clears the model
	task automatic apply_reset();
		reset = 1'b1;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		model_reset();
	endtask

	// Entered and left 1 ns after a rising edge
	task automatic bus_cycle(input logic write, input logic [2:0] addr, input logic [31:0] data,
			input int hold, output logic [31:0] rdata);
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = addr;
		dat_w = data;
		sel = 4'hf;
		@(posedge clk);
		#1;
		while (!ack) begin
			@(posedge clk);
			#1;
		end
		rdata = dat_r;
		repeat (hold) begin		// Host keeps stb up past the ack
			@(posedge clk);
			#1;
		end
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		xact_cnt++;
		@(posedge clk);		// Slave must see stb low
		#1;
	endtask

	task automatic wb_write(input logic [2:0] addr, input logic [31:0] data);
		logic [31:0] discard;
		bus_cycle(1'b1, addr, data, 0, discard);
	endtask

	task automatic wb_read(input logic [2:0] addr, output logic [31:0] data);
		bus_cycle(1'b0, addr, 32'h0000_0000, 0, data);
	endtask

	task automatic send_cmd(input logic [15:0] cmd);
		wb_write(core_pkg::ADDR_CMD, {16'h0000, cmd});
		model_apply(cmd);
	endtask

	task automatic set_pair(input logic [3:0] hi, input logic [15:0] value);
		send_cmd({core_pkg::OP_LD_IMM, hi, value[15:8]});
		send_cmd({core_pkg::OP_LD_IMM, partner_of(hi), value[7:0]});
	endtask

	task automatic check_word(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		check_cnt++;
		value_match: assert (actual === expected) else begin
			error_cnt++;
			$display("[FAIL] %s: %s expected %h actual %h", test_name, what, expected, actual);
		end
	endtask

	// Every readback word against the model
	task automatic check_state();
		logic [31:0] q;
		wb_read(core_pkg::ADDR_CMD, q);
		check_word("last command", {16'h0000, mdl_cmd}, q);
		wb_read(core_pkg::ADDR_BCDE, q);
		check_word("BCDE", {mdl[core_pkg::REG_B], mdl[core_pkg::REG_C],
			mdl[core_pkg::REG_D], mdl[core_pkg::REG_E]}, q);
		wb_read(core_pkg::ADDR_HLAI, q);
		check_word("HLAI", {mdl[core_pkg::REG_H], mdl[core_pkg::REG_L],
			mdl[core_pkg::REG_A], mdl[core_pkg::REG_IR]}, q);
		wb_read(core_pkg::ADDR_SPPC, q);
		check_word("SP and PC", {mdl[core_pkg::REG_SPH], mdl[core_pkg::REG_SPL],
			mdl[core_pkg::REG_PCH], mdl[core_pkg::REG_PCL]}, q);
		wb_read(core_pkg::ADDR_WZ, q);
		check_word("WZ", {16'h0000, mdl[core_pkg::REG_W], mdl[core_pkg::REG_Z]}, q);
		wb_read(core_pkg::ADDR_STAT, q);
		check_word("status", {mdl_sticky, 15'h0000, mdl_cnt}, q);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errs_at_start = total_errors();
		test_cnt++;
	endtask

	task automatic report_test();
		if (total_errors() == errs_at_start) begin
			$display("test %s: ok", test_name);
		end else begin
			$display("test %s: %0d errors", test_name, total_errors() - errs_at_start);
			failed_tests++;
		end
	endtask

	initial begin
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("sim failed");
		$finish;
	end

	initial begin
		logic [31:0] q;
		logic [3:0] dst;
		logic [3:0] src;
		logic [15:0] cmd;
		logic [3:0] pairs [0:4];
		logic [15:0] illegal [0:4];
		clk = 1'b0;
		reset = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = 3'd0;
		dat_w = 32'h0000_0000;
		sel = 4'h0;
		test_cnt = 0;
		failed_tests = 0;
		error_cnt = 0;
		check_cnt = 0;
		xact_cnt = 0;
		ack_cnt = 0;
		ack_len_errs = 0;
		ack_req_errs = 0;
		cycle_cnt = 0;
		void'($urandom(SEED));
		pairs[0] = core_pkg::REG_B;
		pairs[1] = core_pkg::REG_D;
		pairs[2] = core_pkg::REG_H;
		pairs[3] = core_pkg::REG_SPH;
		pairs[4] = core_pkg::REG_W;
		apply_reset();

		start_test("reset_state");
		check_state();
		report_test();

		start_test("load_and_move");
		for (int i = 0; i < 14; i++)
			send_cmd({core_pkg::OP_LD_IMM, 4'(i), 8'($urandom)});
		check_state();
		for (int i = 0; i < 20; i++) begin
			dst = 4'($urandom % 32'd14);
			src = 4'($urandom % 32'd14);
			send_cmd({core_pkg::OP_MOV, dst, src, 4'h0});
		end
		check_state();
		report_test();

		start_test("pair_step");
		for (int i = 0; i < 5; i++) begin
			set_pair(pairs[i], 16'hffff);
			send_cmd({core_pkg::OP_IDU, pairs[i], 8'h00});		// Wraps to 0000
			check_state();
			send_cmd({core_pkg::OP_IDU, pairs[i], 8'h08});		// Back to FFFF
			check_state();
			set_pair(pairs[i], 16'($urandom));
			send_cmd({core_pkg::OP_IDU, pairs[i], 4'h0, 1'($urandom), 3'b000});
		end
		check_state();
		report_test();

		start_test("jump_and_fetch");
		set_pair(core_pkg::REG_W, 16'($urandom));
		send_cmd({core_pkg::OP_JP_ZW, 4'h0, 8'h00});
		check_state();
		for (int i = 0; i < 8; i++) begin
			send_cmd({core_pkg::OP_FETCH, 4'h0, 8'($urandom)});
			check_state();
		end
		report_test();

		start_test("illegal_cmds");
		illegal[0] = {4'($urandom % 32'd10 + 32'd6), 4'($urandom), 8'($urandom)};
		illegal[1] = {core_pkg::OP_LD_IMM, 4'd14, 8'h5a};		// Unused destination
		illegal[2] = {core_pkg::OP_MOV, 4'd15, core_pkg::REG_A, 4'h0};
		illegal[3] = {core_pkg::OP_IDU, core_pkg::REG_A, 8'h00};
		illegal[4] = {core_pkg::OP_IDU, core_pkg::REG_C, 8'h08};
		for (int i = 0; i < 5; i++) begin
			apply_reset();		// Clears the sticky flag for each case
			for (int r = 0; r < 14; r++)
				send_cmd({core_pkg::OP_LD_IMM, 4'(r), 8'($urandom)});
			send_cmd(illegal[i]);
			check_state();
		end
		for (int i = 0; i < 3; i++)
			send_cmd({core_pkg::OP_NOP, 4'($urandom), 8'($urandom)});
		check_state();
		report_test();

		start_test("bus_handshake");
		for (int i = 0; i < 4; i++) begin
			cmd = {core_pkg::OP_LD_IMM, 4'($urandom % 32'd14), 8'($urandom)};
			send_cmd(cmd);
			wb_read(core_pkg::ADDR_CMD, q);
			check_word("command readback", {16'h0000, cmd}, q);
		end
		cmd = {core_pkg::OP_IDU, core_pkg::REG_D, 8'h00};
		bus_cycle(1'b1, core_pkg::ADDR_CMD, {16'h0000, cmd}, 3, q);		// Executes once only
		model_apply(cmd);
		wb_read(3'd6, q);
		check_word("unused address", 32'h0000_0000, q);
		wb_write(3'd7, $urandom);		// Must be ignored
		check_state();
		check_word("ack pulses", 32'(xact_cnt), 32'(ack_cnt));
		report_test();

		$display("tests: %0d run, %0d failed; checks: %0d; errors: %0d", test_cnt,
			failed_tests, check_cnt, total_errors());
		if (total_errors() == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
hw/core_pkg.sv
hw/reg_file.sv
hw/addr_unit.sv
hw/uop_ctrl.sv
hw/core_datapath_top.sv
test/tb_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the datapath testbench with Verilator, runs it, and exits non-zero unless it passed
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module tb_core -f files.f -o tb_core \
	&& ./obj_dir/tb_core | tee /dev/stderr | grep -qx "sim passed" \
	&& echo "PASS: datapath simulation" \
	|| { echo "FAIL: datapath simulation"; exit 1; }
